/* source/icache_cfg_pkg.sv */
package icache_cfg_pkg;

    //////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 32;
    localparam int LINE_WIDTH = 128;
    localparam int NWAY = 2;
    localparam int NSET = 256;

    // Address split, byte offset inside a line first
    localparam int OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);
    localparam int INDEX_WIDTH = $clog2(NSET);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    //////////////////////////////////////////////////
    // Replacement
    //////////////////////////////////////////////////

    localparam int LFSR_WIDTH = 16;

    // x^16 + x^14 + x^13 + x^11
    localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hb400;

    // Any nonzero start value works
    localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 16'hace1;

endpackage

/* source/icache_types_pkg.sv */
package icache_types_pkg;

    import icache_cfg_pkg::*;

    // Fetch address as seen by the cache
    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } icache_addr_t;

    // One tag array entry, 21 bits
    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // Request from the fetch unit
    typedef struct packed {
        logic         valid;
        logic         uncached;
        icache_addr_t addr;
    } fetch_req_t;

    // Write from the controller into the way memories
    typedef struct packed {
        logic [NWAY-1:0]        en;
        logic [INDEX_WIDTH-1:0] index;
        tag_entry_t             entry;
        logic [LINE_WIDTH-1:0]  line;
    } array_wr_t;

endpackage

/* source/icache_way_ram.sv */
`timescale 1ns/10ps

module icache_way_ram
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rd_en_i,
    input  logic [INDEX_WIDTH-1:0] rd_index_i,
    input  array_wr_t              wr_i,
    input  logic                   way_sel_i,
    output tag_entry_t             tag_o,
    output logic [LINE_WIDTH-1:0]  line_o
);

    tag_entry_t            tag_mem [NSET];
    logic [LINE_WIDTH-1:0] line_mem[NSET];

    logic tag_we;
    logic line_we;

    // This way's bit of the shared write mask
    assign tag_we = wr_i.en[way_sel_i];

    // Flush only clears tags, the line is left alone
    assign line_we = tag_we && wr_i.entry.valid;

    //////////////////////////////////////////////////
    // Tag array
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_i.index] <= wr_i.entry;
        end
        if (rd_en_i) begin
            tag_o <= tag_mem[rd_index_i];
        end
    end

    //////////////////////////////////////////////////
    // Data array
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (line_we) begin
            line_mem[wr_i.index] <= wr_i.line;
        end
        if (rd_en_i) begin
            line_o <= line_mem[rd_index_i];
        end
    end

endmodule

/* source/icache_lookup.sv */
`timescale 1ns/10ps

module icache_lookup
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             accept_i,
    input  fetch_req_t                       fetch_i,
    input  tag_entry_t [NWAY-1:0]            tag_i,
    input  logic [NWAY-1:0][LINE_WIDTH-1:0]  line_i,
    input  logic                             refill_valid_i,
    input  logic [LINE_WIDTH-1:0]            refill_line_i,
    input  logic                             done_i,
    output fetch_req_t                       pend_o,
    output logic                             hit_o,
    output logic                             rvalid_o,
    output logic [LINE_WIDTH-1:0]            rdata_o
);

    fetch_req_t            pend_q;
    logic [NWAY-1:0]       way_hit;
    logic [LINE_WIDTH-1:0] hit_line;

    //////////////////////////////////////////////////
    // Pending request
    //////////////////////////////////////////////////

    // A new accept in the hit cycle replaces the finished request
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= '0;
        end else if (accept_i) begin
            pend_q <= fetch_i;
        end else if (rvalid_o) begin
            pend_q.valid <= 1'b0;
        end
    end

    assign pend_o = pend_q;

    //////////////////////////////////////////////////
    // Tag compare and line select
    //////////////////////////////////////////////////

    // Uncached requests never hit, they always go to memory
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = pend_q.valid && !pend_q.uncached && tag_i[w].valid
                         && (tag_i[w].tag == pend_q.addr.tag);
            hit_line = hit_line | (line_i[w] & {LINE_WIDTH{way_hit[w]}});
        end
    end

    assign hit_o = |way_hit;

    // While the controller waits for memory only the refill beat counts
    assign rvalid_o = done_i ? refill_valid_i : hit_o;
    assign rdata_o = done_i ? refill_line_i : hit_line;

    // Fills only go to a line that missed in every way
    a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
        $onehot0(way_hit));

endmodule

/* source/icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_req_t             fetch_i,
    input  logic                   flush_i,
    input  fetch_req_t             pend_i,
    input  logic                   hit_i,
    input  logic                   refill_ready_i,
    input  logic                   refill_valid_i,
    input  logic [LINE_WIDTH-1:0]  refill_line_i,
    output logic                   ack_o,
    output logic                   accept_o,
    output logic                   done_o,
    output logic                   rd_en_o,
    output logic [INDEX_WIDTH-1:0] rd_index_o,
    output array_wr_t              wr_o,
    output logic                   refill_req_o,
    output logic [ADDR_WIDTH-1:0]  refill_addr_o
);

    typedef enum logic [1:0] {
        FLUSH,
        IDLE,
        REQ,
        WAIT
    } state_t;

    state_t                 state_q;
    state_t                 state_d;
    logic [INDEX_WIDTH-1:0] flush_cnt_q;
    logic [LFSR_WIDTH-1:0]  lfsr_q;
    logic                   miss_q;
    logic                   miss_new;
    logic                   flush_last;
    logic                   fill_en;

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FLUSH;
        end else begin
            state_q <= state_d;
        end
    end

    // Pending request looked up and missed
    assign miss_new = (state_q == IDLE) && pend_i.valid && !hit_i;
    assign flush_last = flush_cnt_q == INDEX_WIDTH'(NSET - 1);

    // A miss is serviced before a flush
    always_comb begin
        state_d = state_q;
        case (state_q)
            FLUSH: begin
                if (flush_last) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                if (miss_new) begin
                    state_d = refill_ready_i ? WAIT : REQ;
                end else if (flush_i) begin
                    state_d = FLUSH;
                end
            end
            REQ: begin
                if (refill_ready_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (refill_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = FLUSH;
            end
        endcase
    end

    // Outstanding miss, held until the line arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            miss_q <= 1'b0;
        end else if (miss_new) begin
            miss_q <= 1'b1;
        end else if ((state_q == WAIT) && refill_valid_i) begin
            miss_q <= 1'b0;
        end
    end

    // Wraps back to zero at the end of each flush
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_cnt_q <= '0;
        end else if (state_q == FLUSH) begin
            flush_cnt_q <= flush_cnt_q + 1'b1;
        end
    end

    // Free-running victim source
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[LFSR_WIDTH-2:0], ^(lfsr_q & LFSR_TAPS)};
        end
    end

    //////////////////////////////////////////////////
    // Fetch side and array ports
    //////////////////////////////////////////////////

    assign ack_o = (state_q == IDLE) && fetch_i.valid && !flush_i && !miss_new && !miss_q;
    assign accept_o = ack_o;
    assign rd_en_o = ack_o;
    assign rd_index_o = fetch_i.addr.index;
    assign done_o = state_q == WAIT;

    // Fill follows the outstanding miss
    assign fill_en = refill_valid_i && miss_q && !pend_i.uncached;

    always_comb begin
        wr_o.en = '0;
        wr_o.index = pend_i.addr.index;
        wr_o.entry.valid = 1'b1;
        wr_o.entry.tag = pend_i.addr.tag;
        wr_o.line = refill_line_i;
        if (state_q == FLUSH) begin
            wr_o.en = '1;
            wr_o.index = flush_cnt_q;
            wr_o.entry = '0;
        end else if (fill_en) begin
            wr_o.en[lfsr_q[0]] = 1'b1;
        end
    end

    // Refill request, line aligned
    assign refill_req_o = miss_new || ((state_q == REQ) && miss_q);
    assign refill_addr_o = {pend_i.addr.tag, pend_i.addr.index, {OFFSET_WIDTH{1'b0}}};

    a_refill_hold: assert property (@(posedge clk) disable iff (rst)
        refill_req_o && !refill_ready_i |=> refill_req_o && $stable(refill_addr_o));

    a_no_write_idle: assert property (@(posedge clk) disable iff (rst)
        state_q == IDLE |-> wr_o.en == '0);

endmodule

/* source/icache_top.sv */
`timescale 1ns/10ps

module icache_top
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_req_t            fetch_i,
    input  logic                  flush_i,
    output logic                  ack_o,
    output logic                  rvalid_o,
    output logic [LINE_WIDTH-1:0] rdata_o,
    input  logic                  refill_ready_i,
    input  logic                  refill_valid_i,
    input  logic [LINE_WIDTH-1:0] refill_line_i,
    output logic                  refill_req_o,
    output logic [ADDR_WIDTH-1:0] refill_addr_o
);

    logic                            accept;
    logic                            done;
    logic                            rd_en;
    logic                            hit;
    logic [INDEX_WIDTH-1:0]          rd_index;
    array_wr_t                       wr;
    fetch_req_t                      pend;
    tag_entry_t [NWAY-1:0]           way_tag;
    logic [NWAY-1:0][LINE_WIDTH-1:0] way_line;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .fetch_i       (fetch_i),
        .flush_i       (flush_i),
        .pend_i        (pend),
        .hit_i         (hit),
        .refill_ready_i(refill_ready_i),
        .refill_valid_i(refill_valid_i),
        .refill_line_i (refill_line_i),
        .ack_o         (ack_o),
        .accept_o      (accept),
        .done_o        (done),
        .rd_en_o       (rd_en),
        .rd_index_o    (rd_index),
        .wr_o          (wr),
        .refill_req_o  (refill_req_o),
        .refill_addr_o (refill_addr_o)
    );

    icache_lookup u_lookup (
        .clk           (clk),
        .rst           (rst),
        .accept_i      (accept),
        .fetch_i       (fetch_i),
        .tag_i         (way_tag),
        .line_i        (way_line),
        .refill_valid_i(refill_valid_i),
        .refill_line_i (refill_line_i),
        .done_i        (done),
        .pend_o        (pend),
        .hit_o         (hit),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o)
    );

    // One memory per way, identity tied here
    for (genvar w = 0; w < NWAY; w++) begin : g_way
        icache_way_ram u_way_ram (
            .clk       (clk),
            .rd_en_i   (rd_en),
            .rd_index_i(rd_index),
            .wr_i      (wr),
            .way_sel_i (1'(w)),
            .tag_o     (way_tag[w]),
            .line_o    (way_line[w])
        );
    end

endmodule

/* tests/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
();

    typedef enum int {
        EXP_MISS,
        EXP_HIT,
        DO_FLUSH
    } test_kind_t;

    logic                  clk;
    logic                  rst;
    fetch_req_t            fetch_i;
    logic                  flush_i;
    logic                  ack_o;
    logic                  rvalid_o;
    logic [LINE_WIDTH-1:0] rdata_o;
    logic                  refill_ready_i;
    logic                  refill_valid_i;
    logic [LINE_WIDTH-1:0] refill_line_i;
    logic                  refill_req_o;
    logic [ADDR_WIDTH-1:0] refill_addr_o;

    // Test table read from the data file
    string                 test_name[64];
    logic [ADDR_WIDTH-1:0] test_addr[64];
    logic                  test_unc[64];
    test_kind_t            test_kind[64];
    int                    num_tests = 0;
    logic                  tests_loaded = 1'b0;

    // Accepted requests still waiting for their line, oldest first
    int                    acc_q[$];
    int                    acc_cycle_q[$];
    logic                  front_refilled = 1'b0;

    int                    cur_test = 0;
    int                    cycle_count = 0;
    int                    quiet_until = 0;
    int                    error_count = 0;
    int                    access_count = 0;
    int                    response_count = 0;
    logic [31:0]           rng_state;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    icache_top u_icache_top (
        .clk           (clk),
        .rst           (rst),
        .fetch_i       (fetch_i),
        .flush_i       (flush_i),
        .ack_o         (ack_o),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .refill_ready_i(refill_ready_i),
        .refill_valid_i(refill_valid_i),
        .refill_line_i (refill_line_i),
        .refill_req_o  (refill_req_o),
        .refill_addr_o (refill_addr_o)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] line_base(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    endfunction

    // Word k of a line holds the line address plus k
    function automatic logic [LINE_WIDTH-1:0] model_line(input logic [ADDR_WIDTH-1:0] addr);
        logic [ADDR_WIDTH-1:0] base;
        logic [LINE_WIDTH-1:0] line;
        base = line_base(addr);
        for (int k = 0; k < LINE_WIDTH / 32; k++) begin
            line[k*32 +: 32] = base + k;
        end
        return line;
    endfunction

    task automatic load_tests();
        int                    fd;
        int                    code;
        int                    fields;
        int                    unc;
        string                 line;
        string                 name;
        string                 outcome;
        logic [ADDR_WIDTH-1:0] addr;
        fd = $fopen("tests/icache_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/icache_tests.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %d %s", name, addr, unc, outcome);
                if (fields == 4 && num_tests < 64) begin
                    test_name[num_tests] = name;
                    test_addr[num_tests] = addr;
                    test_unc[num_tests] = (unc != 0);
                    if (outcome == "hit") begin
                        test_kind[num_tests] = EXP_HIT;
                        num_tests++;
                    end else if (outcome == "miss") begin
                        test_kind[num_tests] = EXP_MISS;
                        num_tests++;
                    end else if (outcome == "flush") begin
                        test_kind[num_tests] = DO_FLUSH;
                        num_tests++;
                    end else begin
                        $display("Unknown outcome %s for test %s", outcome, name);
                        error_count++;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // Present one request and hold it until the cache acks it
    task automatic issue_access(input int t);
        cur_test = t;
        access_count++;
        fetch_i.valid = 1'b1;
        fetch_i.uncached = test_unc[t];
        fetch_i.addr = test_addr[t];
        do begin
            @(posedge clk);
        end while (!ack_o);
        @(negedge clk);
        fetch_i = '0;
    endtask

    task automatic wait_drained();
        while (acc_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    initial begin
        int                    ready_delay;
        int                    valid_delay;
        logic [ADDR_WIDTH-1:0] req_addr;
        refill_ready_i = 1'b0;
        refill_valid_i = 1'b0;
        refill_line_i = '0;
        rng_state = 32'h396bac3c;
        forever begin
            @(posedge clk);
            if (!rst && refill_req_o) begin
                req_addr = refill_addr_o;
                rng_state = next_random(rng_state);
                ready_delay = int'(rng_state % 8);
                @(negedge clk);
                repeat (ready_delay) @(negedge clk);
                refill_ready_i = 1'b1;
                @(negedge clk);
                refill_ready_i = 1'b0;
                rng_state = next_random(rng_state);
                valid_delay = 1 + int'(rng_state % 7);
                repeat (valid_delay - 1) @(negedge clk);
                refill_line_i = model_line(req_addr);
                refill_valid_i = 1'b1;
                @(negedge clk);
                refill_valid_i = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Response monitor
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        int   idx;
        int   acc_cycle;
        logic seen_hit;
        cycle_count++;
        if (rst) begin
            quiet_until = cycle_count + NSET;
        end else begin
            assert (!(ack_o && cycle_count <= quiet_until)) else begin
                $display("Request accepted during a flush at cycle %0d", cycle_count);
                error_count++;
            end
            if (flush_i) begin
                quiet_until = cycle_count + NSET;
            end
            if (refill_req_o) begin
                assert (acc_q.size() > 0) else begin
                    $display("Refill request with no access pending");
                    error_count++;
                end
                if (acc_q.size() > 0) begin
                    idx = acc_q[0];
                    front_refilled = 1'b1;
                    assert (refill_addr_o == line_base(test_addr[idx])) else begin
                        $display("ERR %s refill_addr expected %h actual %h", test_name[idx],
                                 line_base(test_addr[idx]), refill_addr_o);
                        error_count++;
                    end
                end
            end
            if (rvalid_o) begin
                assert (acc_q.size() > 0) else begin
                    $display("Line returned with no access pending");
                    error_count++;
                end
                if (acc_q.size() > 0) begin
                    idx = acc_q.pop_front();
                    acc_cycle = acc_cycle_q.pop_front();
                    seen_hit = !front_refilled && (cycle_count == acc_cycle + 1);
                    response_count++;
                    assert (seen_hit == (test_kind[idx] == EXP_HIT)) else begin
                        $display("ERR %s expected %s actual %s", test_name[idx],
                                 (test_kind[idx] == EXP_HIT) ? "hit" : "miss",
                                 seen_hit ? "hit" : "miss");
                        error_count++;
                    end
                    assert (rdata_o == model_line(test_addr[idx])) else begin
                        $display("ERR %s expected %h actual %h", test_name[idx],
                                 model_line(test_addr[idx]), rdata_o);
                        error_count++;
                    end
                    if (front_refilled) begin
                        assert (refill_valid_i) else begin
                            $display("Miss data for %s came outside the refill beat",
                                     test_name[idx]);
                            error_count++;
                        end
                    end
                    // Next request is taken in the hit cycle
                    if (seen_hit && fetch_i.valid) begin
                        assert (ack_o) else begin
                            $display("Waiting request not accepted in the hit cycle of %s",
                                     test_name[idx]);
                            error_count++;
                        end
                    end
                    front_refilled = 1'b0;
                end
            end
            if (ack_o) begin
                acc_q.push_back(cur_test);
                acc_cycle_q.push_back(cycle_count);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus and summary
    //////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        fetch_i = '0;
        flush_i = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            if (test_kind[t] == DO_FLUSH) begin
                wait_drained();
                flush_i = 1'b1;
                @(negedge clk);
                flush_i = 1'b0;
            end else begin
                issue_access(t);
            end
        end
        wait_drained();
        @(negedge clk);
        assert (response_count == access_count) else begin
            $display("Accesses and returned lines differ in number");
            error_count++;
        end
        $display("Summary: %0d accesses, %0d responses, %0d errors",
                 access_count, response_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Limit scales with the test count, plus room for the flushes
    initial begin
        int limit;
        wait (tests_loaded);
        limit = num_tests * 40 + NSET * 3;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the cache stopped responding", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tests/icache_tests.txt */
# Columns: test name, hex address, uncached flag, expected outcome (hit or miss)
# A flush outcome pulses flush_i, its address and uncached columns are ignored
first_miss       00001000 0 miss
same_addr_hit    00001000 0 hit
offset4_hit      00001004 0 hit
offset_c_hit     0000100c 0 hit
offset8_hit      00001008 0 hit
line2_miss       00002230 0 miss
line2_hit        00002234 0 hit
unc_miss         00003040 1 miss
unc_repeat_miss  00003040 1 miss
unc_then_cached  00003048 0 miss
cached_hit       0000304c 0 hit
set50_a_miss     00010500 0 miss
set50_a_hit      00010508 0 hit
set50_b_miss     00020500 0 miss
set50_b_hit      00020504 0 hit
set50_c_miss     abcde504 0 miss
set50_c_hit      abcde500 0 hit
flush_all        00000000 0 flush
post_a_miss      00001000 0 miss
post_b_miss      00002230 0 miss
post_c_miss      00020500 0 miss
post_d_miss      0000304c 0 miss
b2b_0            00001004 0 hit
b2b_1            00002238 0 hit
b2b_2            00001008 0 hit
b2b_3            00020504 0 hit
b2b_4            0000223c 0 hit
b2b_5            00003044 0 hit
b2b_6            0000100c 0 hit

/* list.f */
source/icache_cfg_pkg.sv
source/icache_types_pkg.sv
source/icache_way_ram.sv
source/icache_lookup.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/icache_tb.sv

/* Makefile */
TOP := icache_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
